/* dv/cpuChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuChecker (
  input  wire logic                         CLK,
  input  wire logic                         RESET,
  input  wire logic [cpuPkg::addrWidth-1:0] romAddr,
  input  wire cpuPkg::wbMaster_t            wbOut,
  input  wire logic                         wbAck,
  input  wire logic [cpuPkg::irqLines-1:0]  irqRaise,
  input  wire logic [cpuPkg::irqLines-1:0]  irqAck,
  input  wire logic                         idle,
  // Row under test, as loaded into RAM and ROM
  input  wire logic [3:0]                   rowOp,
  input  wire logic [cpuPkg::dataWidth-1:0] rowA,
  input  wire logic [cpuPkg::dataWidth-1:0] rowB,
  input  wire logic [cpuPkg::dataWidth-1:0] rowTaken,
  input  wire logic [cpuPkg::dataWidth-1:0] rowFallThrough,
  output int                                errorCount
);
  import cpuPkg::*;

  // Last cycle's bus state
  wbMaster_t           prevWb;
  logic                prevHeld;
  logic [irqLines-1:0] prevAck;
  int                  writeCount;

  initial begin
    errorCount = 0;
    writeCount = 0;
    prevHeld   = 1'b0;
    prevAck    = '0;
  end

  // ALU rules, codes A to F pass A through
  function automatic logic [dataWidth-1:0] expectedAlu(input logic [3:0] op,
      input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    case (op)
      4'h0:    return a + b;
      4'h1:    return a - b;
      4'h2:    return a * b;
      4'h3:    return a & b;
      4'h4:    return a | b;
      4'h5:    return a ^ b;
      4'h6:    return a << 1;
      4'h7:    return a >> 1;
      4'h8:    return a + 8'd1;
      4'h9:    return a - 8'd1;
      default: return a;
    endcase
  endfunction

  task automatic reportMismatch(input string what, input logic [7:0] got,
      input logic [7:0] expected);
    $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, expected);
    errorCount++;
  endtask

  task automatic reportFailure(input string what);
    $display("Error at %0t: %s", $time, what);
    errorCount++;
  endtask

  // Called once the run is over
  task automatic finalWriteCheck(input int expected);
    if (writeCount != expected) begin
      $display("Mismatch at %0t: %0d stores seen, expected %0d", $time, writeCount, expected);
      errorCount++;
    end
  endtask

  //////////////////////////////
  // Per-cycle checks, mid-cycle

  always @(negedge CLK) begin : sampleCycle
    logic [irqLines-1:0] expectedAck;
    if (RESET) begin
      if (wbOut.cyc || wbOut.stb || wbOut.we || (|irqAck))
        reportFailure("bus or interrupt outputs are not low during reset");
      if (romAddr != '0) reportMismatch("ROM address in reset", romAddr, 8'h00);
    end else begin
      // Classic cycle rules
      if (wbOut.cyc != wbOut.stb) reportFailure("cyc and stb differ");
      if (prevHeld && wbOut != prevWb) reportFailure("Wishbone outputs changed before ack");

      // Completed stores
      if (wbOut.cyc && wbOut.stb && wbOut.we && wbAck) begin
        writeCount++;
        case (wbOut.adr)
          8'h80: if (wbOut.datOut !== expectedAlu(rowOp, rowA, rowB))
            reportMismatch("store to 80", wbOut.datOut, expectedAlu(rowOp, rowA, rowB));
          8'h81: if (wbOut.datOut !== ((rowA < rowB) ? rowTaken : rowFallThrough))
            reportMismatch("store to 81", wbOut.datOut,
              (rowA < rowB) ? rowTaken : rowFallThrough);
          8'h82: if (wbOut.datOut !== rowB) reportMismatch("store to 82", wbOut.datOut, rowB);
          // Skipped store at 83 lands here too
          default: reportFailure($sformatf("store to unexpected address %h", wbOut.adr));
        endcase
      end

      // Line 0 wins, ack only from idle
      if (|irqAck) begin
        expectedAck = irqRaise[0] ? 2'b01 : {irqRaise[1], 1'b0};
        if (irqAck != expectedAck) reportMismatch("irqAck", irqAck, expectedAck);
        if (|prevAck) reportFailure("irqAck stayed high for two cycles");
        if (!idle) reportFailure("irqAck given while a thread is running");
      end
    end
    prevWb   = wbOut;
    prevHeld = wbOut.stb && !wbAck && !RESET;
    prevAck  = irqAck;
  end

endmodule

`default_nettype wire

/* dv/cpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuTb;
  import cpuPkg::*;

  localparam int numRows      = 16;
  localparam int timeoutLimit = numRows * 80 + 200;

  // One table row
  typedef struct packed {
    logic [3:0]           op;
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
  } row_t;

  logic                 CLK;
  logic                 RESET;
  logic [addrWidth-1:0] romAddr;
  logic [dataWidth-1:0] romData;
  wbMaster_t            wbOut;
  logic [dataWidth-1:0] wbDatIn;
  logic                 wbAck;
  logic [irqLines-1:0]  irqRaise;
  logic [irqLines-1:0]  irqAck;

  // Row values seen by the checker
  logic [3:0]           rowOp;
  logic [dataWidth-1:0] rowA;
  logic [dataWidth-1:0] rowB;
  logic [dataWidth-1:0] rowTaken;
  logic [dataWidth-1:0] rowFallThrough;

  logic [dataWidth-1:0] rom [256];
  logic [dataWidth-1:0] ram [256];
  row_t                 rows [numRows];
  logic [31:0]          rngState;
  logic                 slaveBusy;
  int                   waitLeft;
  int                   cycleCount;
  int                   errorCount;

  microCpu dut (
    .CLK      (CLK),
    .RESET    (RESET),
    .romAddr  (romAddr),
    .romData  (romData),
    .wbOut    (wbOut),
    .wbDatIn  (wbDatIn),
    .wbAck    (wbAck),
    .irqRaise (irqRaise),
    .irqAck   (irqAck)
  );

  cpuChecker cpuCheck (
    .CLK            (CLK),
    .RESET          (RESET),
    .romAddr        (romAddr),
    .wbOut          (wbOut),
    .wbAck          (wbAck),
    .irqRaise       (irqRaise),
    .irqAck         (irqAck),
    .idle           (dut.sequencer.idle),
    .rowOp          (rowOp),
    .rowA           (rowA),
    .rowB           (rowB),
    .rowTaken       (rowTaken),
    .rowFallThrough (rowFallThrough),
    .errorCount     (errorCount)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  //////////////////////////////
  // Memory models

  // Synchronous ROM, one cycle read latency
  always begin : romModel
    logic [dataWidth-1:0] fetched;
    @(posedge CLK);
    fetched = rom[romAddr];
    #2;
    romData = fetched;
  end

  // RAM slave, 0 to 3 wait cycles per access
  always begin : ramSlave
    @(posedge CLK);
    if (wbOut.cyc && wbOut.stb && !wbAck) begin
      if (!slaveBusy) begin
        rngState  = xorshift(rngState);
        waitLeft  = rngState[1:0];
        slaveBusy = 1'b1;
      end
      if (waitLeft == 0) begin
        #2;
        wbDatIn = ram[wbOut.adr];
        if (wbOut.we) ram[wbOut.adr] = wbOut.datOut;
        wbAck     = 1'b1;
        slaveBusy = 1'b0;
      end else begin
        waitLeft--;
      end
    end else if (wbAck) begin
      // Master closes the cycle after the ack
      #2;
      wbAck = 1'b0;
    end
  end

  // Source drops its line once acked
  always begin : irqSource
    logic [irqLines-1:0] ackSeen;
    @(posedge CLK);
    ackSeen = irqAck;
    if (|ackSeen) begin
      #2;
      irqRaise = irqRaise & ~ackSeen;
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutLimit) begin
      @(posedge CLK);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the stores never completed", cycleCount);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // Program and table

  task automatic placeBytes(input logic [7:0] addr, input logic [7:0] b0, input logic [7:0] b1);
    rom[addr]        = b0;
    rom[addr + 8'd1] = b1;
  endtask

  task automatic loadProgram;
    for (int i = 0; i < 256; i++) begin
      rom[i] = i[7:0] ^ 8'h5A;
      ram[i] = ~i[7:0];
    end
    rom[8'h00] = 8'h0A;
    // Thread 0, operands then ALU into A
    placeBytes(8'h10, 8'h00, 8'h00);
    placeBytes(8'h12, 8'h01, 8'h01);
    rom[8'h14] = 8'h04;
    placeBytes(8'h15, 8'h02, 8'h80);
    placeBytes(8'h17, 8'h00, 8'h00);
    // Less taken picks RAM 02
    placeBytes(8'h19, 8'h07, 8'h1F);
    placeBytes(8'h1B, 8'h00, 8'h03);
    placeBytes(8'h1D, 8'h09, 8'h21);
    placeBytes(8'h1F, 8'h00, 8'h02);
    placeBytes(8'h21, 8'h02, 8'h81);
    // Jump over the store to 83
    placeBytes(8'h23, 8'h09, 8'h27);
    placeBytes(8'h25, 8'h02, 8'h83);
    rom[8'h27] = 8'h0A;
    // Thread 1
    placeBytes(8'h30, 8'h03, 8'h82);
    rom[8'h32] = 8'h0A;
    rom[irqVector0] = 8'h10;
    rom[irqVector1] = 8'h30;
    // Op, A, B; equal and greater operands mixed in
    rows[0]  = {4'h0, 8'h3C, 8'h51};
    rows[1]  = {4'h1, 8'h20, 8'h7F};
    rows[2]  = {4'h2, 8'h13, 8'h13};
    rows[3]  = {4'h3, 8'hF0, 8'h3C};
    rows[4]  = {4'h4, 8'h0F, 8'hA0};
    rows[5]  = {4'h5, 8'h55, 8'h55};
    rows[6]  = {4'h6, 8'hC3, 8'h01};
    rows[7]  = {4'h7, 8'h81, 8'h90};
    rows[8]  = {4'h8, 8'hFF, 8'h10};
    rows[9]  = {4'h9, 8'h00, 8'h00};
    rows[10] = {4'hA, 8'h6B, 8'h20};
    rows[11] = {4'hB, 8'h9A, 8'h9A};
    rows[12] = {4'hC, 8'h7E, 8'h3F};
    rows[13] = {4'hD, 8'h01, 8'hFE};
    rows[14] = {4'hE, 8'hC8, 8'h64};
    rows[15] = {4'hF, 8'h12, 8'hEE};
  endtask

  task automatic waitForWrite(input logic [addrWidth-1:0] addr);
    @(negedge CLK);
    while (!(wbOut.cyc && wbOut.we && wbAck && wbOut.adr == addr)) @(negedge CLK);
  endtask

  //////////////////////////////
  // Stimulus

  initial begin
    RESET          = 1'b1;
    romData        = '0;
    wbDatIn        = '0;
    wbAck          = 1'b0;
    irqRaise       = '0;
    rowOp          = '0;
    rowA           = '0;
    rowB           = '0;
    rowTaken       = '0;
    rowFallThrough = '0;
    slaveBusy      = 1'b0;
    waitLeft       = 0;
    rngState       = 32'd39421;
    loadProgram();
    repeat (3) @(posedge CLK);
    #2 RESET = 1'b0;

    for (int i = 0; i < numRows; i++) begin
      @(posedge CLK);
      #2;
      rowOp          = rows[i].op;
      rowA           = rows[i].a;
      rowB           = rows[i].b;
      rowTaken       = 8'hA0 + i[7:0];
      rowFallThrough = 8'h50 + i[7:0];
      ram[8'h00]     = rowA;
      ram[8'h01]     = rowB;
      ram[8'h02]     = rowTaken;
      ram[8'h03]     = rowFallThrough;
      rom[8'h14]     = {rows[i].op, 4'h4};
      // Both lines at once, line 0 thread runs first
      irqRaise = '1;
      waitForWrite(8'h81);
      waitForWrite(8'h82);
    end

    repeat (4) @(posedge CLK);
    cpuCheck.finalWriteCheck(3 * numRows);
    $display("Error count: %0d", errorCount);
    if (errorCount == 0) $display("TESTS PASSED");
    else $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/cpuPkg.sv
verilog/aluUnit.sv
verilog/busMaster.sv
verilog/interruptArbiter.sv
verilog/programSequencer.sv
verilog/microCpu.sv
dv/cpuChecker.sv
dv/cpuTb.sv

/* verilog/aluUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
  input  wire logic [cpuPkg::dataWidth-1:0] a,
  input  wire logic [cpuPkg::dataWidth-1:0] b,
  input  wire cpuPkg::aluOp_t               op,
  output logic      [cpuPkg::dataWidth-1:0] result,
  output cpuPkg::aluFlags_t                 flags
);
  import cpuPkg::*;

  //////////////////////////////
  // Operation select

  always_comb begin
    case (op)
      aluAdd:        result = a + b;
      aluSubtract:   result = a - b;
      // Only the low byte of the product is kept
      aluMultiply:   result = a * b;
      aluAnd:        result = a & b;
      aluOr:         result = a | b;
      aluXor:        result = a ^ b;
      // Shifts act on A only, zero fill
      aluShiftLeft:  result = a << 1;
      aluShiftRight: result = a >> 1;
      aluIncrement:  result = a + 1'b1;
      aluDecrement:  result = a - 1'b1;
      // Reserved codes
      default:       result = a;
    endcase
  end

  //////////////////////////////
  // Compare flags

  // Always valid, independent of op
  always_comb begin
    flags.equal   = (a == b);
    flags.less    = (a < b);
    flags.greater = (a > b);
  end

endmodule

`default_nettype wire

/* verilog/busMaster.sv */
`timescale 1ns/10ps
`default_nettype none

module busMaster (
  input  wire logic                         CLK,
  input  wire logic                         RESET,
  input  wire cpuPkg::busRequest_t          request,
  output cpuPkg::wbMaster_t                 wbOut,
  input  wire logic [cpuPkg::dataWidth-1:0] wbDatIn,
  input  wire logic                         wbAck,
  output logic                              done,
  output logic      [cpuPkg::dataWidth-1:0] readData
);
  import cpuPkg::*;

  // Cycle state, cyc and stb move together
  logic cycleOpen;
  logic writeEn;
  // Latched request payload
  logic [addrWidth-1:0] adrReg;
  logic [dataWidth-1:0] datReg;

  //////////////////////////////
  // Cycle control

  always_ff @(posedge CLK) begin
    if (RESET) begin
      cycleOpen <= 1'b0;
      writeEn   <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (request.start) begin
        cycleOpen <= 1'b1;
        writeEn   <= request.write;
      end else if (cycleOpen && wbAck) begin
        // Close the cycle and report back
        cycleOpen <= 1'b0;
        writeEn   <= 1'b0;
        done      <= 1'b1;
      end
    end
  end

  // Payload is held until the next start
  always_ff @(posedge CLK) begin
    if (request.start) begin
      adrReg <= request.addr;
      datReg <= request.data;
    end
    // Read data sampled in the ack cycle
    if (cycleOpen && wbAck) readData <= wbDatIn;
  end

  assign wbOut = '{cyc: cycleOpen, stb: cycleOpen, we: writeEn, adr: adrReg, datOut: datReg};

  //////////////////////////////
  // Checks

  // Address and direction stay put while the slave stalls
  assert property (@(posedge CLK) disable iff (RESET)
    wbOut.stb && !wbAck |=> $stable(wbOut.adr) && $stable(wbOut.we))
    else $error("Wishbone outputs changed before ack");

  // Sequencer must wait for done before the next request
  assert property (@(posedge CLK) disable iff (RESET) request.start |-> !cycleOpen)
    else $error("Bus request while a cycle is open");

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  //////////////////////////////
  // Widths

  // Data bytes, registers A and B
  localparam int dataWidth = 8;
  // ROM address and data bus address
  localparam int addrWidth = 8;
  // Interrupt request lines
  localparam int irqLines = 2;

  // ROM bytes holding the thread start addresses
  localparam logic [addrWidth-1:0] irqVector0 = 8'hFF;
  localparam logic [addrWidth-1:0] irqVector1 = 8'hFE;

  //////////////////////////////
  // Instruction set

  // Low nibble of each opcode byte
  // Unlisted codes run as a one-byte no-operation
  typedef enum logic [3:0] {
    loadA         = 4'h0,
    loadB         = 4'h1,
    storeA        = 4'h2,
    storeB        = 4'h3,
    aluToA        = 4'h4,
    aluToB        = 4'h5,
    branchEqual   = 4'h6,
    branchLess    = 4'h7,
    branchGreater = 4'h8,
    gotoAddr      = 4'h9,
    gotoIdle      = 4'hA
  } opcode_t;

  // High nibble, selects the ALU operation
  // Unlisted codes pass A through
  typedef enum logic [3:0] {
    aluAdd        = 4'h0,
    aluSubtract   = 4'h1,
    aluMultiply   = 4'h2,
    aluAnd        = 4'h3,
    aluOr         = 4'h4,
    aluXor        = 4'h5,
    aluShiftLeft  = 4'h6,
    aluShiftRight = 4'h7,
    aluIncrement  = 4'h8,
    aluDecrement  = 4'h9
  } aluOp_t;

  // Unsigned compare of A against B
  typedef struct packed {
    logic equal;
    logic less;
    logic greater;
  } aluFlags_t;

  //////////////////////////////
  // Bus structs

  // Sequencer to bus master, start is a single-cycle pulse
  typedef struct packed {
    logic                 start;
    logic                 write;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] data;
  } busRequest_t;

  // Wishbone classic master outputs
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [addrWidth-1:0] adr;
    logic [dataWidth-1:0] datOut;
  } wbMaster_t;

endpackage

`default_nettype wire

/* verilog/interruptArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module interruptArbiter (
  input  wire logic                        CLK,
  input  wire logic                        RESET,
  input  wire logic [cpuPkg::irqLines-1:0] irqRaise,
  input  wire logic                        idle,
  output logic      [cpuPkg::irqLines-1:0] irqAck,
  output logic                             grant,
  output logic      [cpuPkg::addrWidth-1:0] vectorAddr
);
  import cpuPkg::*;

  logic                 grantNext;
  logic [irqLines-1:0]  winner;
  logic [addrWidth-1:0] winnerVector;

  // Line 0 has priority over line 1
  always_comb begin
    winner       = '0;
    winnerVector = irqVector1;
    if (irqRaise[0]) begin
      winner[0]    = 1'b1;
      winnerVector = irqVector0;
    end else if (irqRaise[1]) begin
      winner[1] = 1'b1;
    end
  end

  // No second grant while the sequencer still shows idle from the last one
  assign grantNext = idle && !grant && (|irqRaise);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      grant  <= 1'b0;
      irqAck <= '0;
    end else begin
      grant  <= grantNext;
      irqAck <= grantNext ? winner : '0;
    end
  end

  // Vector only matters alongside grant
  always_ff @(posedge CLK) begin
    if (grantNext) vectorAddr <= winnerVector;
  end

  // Ack is always a single-cycle pulse
  assert property (@(posedge CLK) disable iff (RESET) (|irqAck) |=> !(|irqAck))
    else $error("irqAck held for more than one cycle");

endmodule

`default_nettype wire

/* verilog/microCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module microCpu (
  input  wire logic                         CLK,
  input  wire logic                         RESET,
  // Program ROM
  output logic      [cpuPkg::addrWidth-1:0] romAddr,
  input  wire logic [cpuPkg::dataWidth-1:0] romData,
  // Wishbone master
  output cpuPkg::wbMaster_t                 wbOut,
  input  wire logic [cpuPkg::dataWidth-1:0] wbDatIn,
  input  wire logic                         wbAck,
  // Interrupts
  input  wire logic [cpuPkg::irqLines-1:0]  irqRaise,
  output logic      [cpuPkg::irqLines-1:0]  irqAck
);
  import cpuPkg::*;

  busRequest_t          request;
  logic                 done;
  logic [dataWidth-1:0] readData;
  logic                 grant;
  logic [addrWidth-1:0] vectorAddr;
  logic                 idle;

  programSequencer sequencer (
    .CLK        (CLK),
    .RESET      (RESET),
    .romAddr    (romAddr),
    .romData    (romData),
    .request    (request),
    .done       (done),
    .readData   (readData),
    .grant      (grant),
    .vectorAddr (vectorAddr),
    .idle       (idle)
  );

  busMaster master (
    .CLK      (CLK),
    .RESET    (RESET),
    .request  (request),
    .wbOut    (wbOut),
    .wbDatIn  (wbDatIn),
    .wbAck    (wbAck),
    .done     (done),
    .readData (readData)
  );

  interruptArbiter arbiter (
    .CLK        (CLK),
    .RESET      (RESET),
    .irqRaise   (irqRaise),
    .idle       (idle),
    .irqAck     (irqAck),
    .grant      (grant),
    .vectorAddr (vectorAddr)
  );

endmodule

`default_nettype wire

/* verilog/programSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module programSequencer (
  input  wire logic                         CLK,
  input  wire logic                         RESET,
  output logic      [cpuPkg::addrWidth-1:0] romAddr,
  input  wire logic [cpuPkg::dataWidth-1:0] romData,
  output cpuPkg::busRequest_t               request,
  input  wire logic                         done,
  input  wire logic [cpuPkg::dataWidth-1:0] readData,
  input  wire logic                         grant,
  input  wire logic [cpuPkg::addrWidth-1:0] vectorAddr,
  output logic                              idle
);
  import cpuPkg::*;

  //////////////////////////////
  // State encoding

  typedef enum logic [3:0] {
    stIdle,      // Wait for a grant
    stVecWait,   // Vector address on the ROM port
    stVecLoad,   // Vector byte arrives, load the thread start
    stSettle,    // New ROM address settles
    stDecode,    // Opcode on romData
    stAluSave,   // Store ALU result
    stMemWait,   // Operand address on the ROM port
    stMemIssue,  // Address byte arrives, start the bus cycle
    stMemBus,    // Wait for done
    stJumpWait,  // Target address on the ROM port
    stJumpLoad,  // Target byte arrives
    stIdleWait   // Thread ends
  } state_t;

  state_t state, nextState;

  // Program counter and fetch offset for the second byte
  logic [addrWidth-1:0] pc, nextPc;
  logic                 fetchOffset, nextFetchOffset;

  // Working registers
  logic [dataWidth-1:0] regA, nextRegA;
  logic [dataWidth-1:0] regB, nextRegB;

  // Decoded instruction details, kept past the opcode byte
  logic useB, nextUseB;
  logic memWrite, nextMemWrite;
  logic jumpTaken, nextJumpTaken;

  // ALU hookup
  opcode_t              opcode;
  aluOp_t               aluOp;
  logic [dataWidth-1:0] aluResult;
  aluFlags_t            flags;

  assign opcode = opcode_t'(romData[3:0]);
  assign aluOp  = aluOp_t'(romData[7:4]);

  aluUnit alu (
    .a      (regA),
    .b      (regB),
    .op     (aluOp),
    .result (aluResult),
    .flags  (flags)
  );

  // ROM is addressed one byte ahead while the second byte is fetched
  assign romAddr = pc + {{(addrWidth-1){1'b0}}, fetchOffset};
  assign idle    = (state == stIdle);

  // Bus request, start only in the issue state
  always_comb begin
    request.start = (state == stMemIssue);
    request.write = memWrite;
    request.addr  = romData;
    request.data  = useB ? regB : regA;
  end

  //////////////////////////////
  // Registers

  always_ff @(posedge CLK) begin
    if (RESET) begin
      // Fetch from address 0 after a settle cycle
      state       <= stSettle;
      pc          <= '0;
      fetchOffset <= 1'b0;
      regA        <= '0;
      regB        <= '0;
      useB        <= 1'b0;
      memWrite    <= 1'b0;
      jumpTaken   <= 1'b0;
    end else begin
      state       <= nextState;
      pc          <= nextPc;
      fetchOffset <= nextFetchOffset;
      regA        <= nextRegA;
      regB        <= nextRegB;
      useB        <= nextUseB;
      memWrite    <= nextMemWrite;
      jumpTaken   <= nextJumpTaken;
    end
  end

  //////////////////////////////
  // Next state

  always_comb begin
    // Hold by default, offset drops back to 0
    nextState       = state;
    nextPc          = pc;
    nextFetchOffset = 1'b0;
    nextRegA        = regA;
    nextRegB        = regB;
    nextUseB        = useB;
    nextMemWrite    = memWrite;
    nextJumpTaken   = jumpTaken;

    case (state)
      // Thread start
      stIdle: begin
        if (grant) begin
          nextPc    = vectorAddr;
          nextState = stVecWait;
        end
      end
      stVecWait:  nextState = stVecLoad;
      stVecLoad: begin
        nextPc    = romData;
        nextState = stSettle;
      end
      stSettle:   nextState = stDecode;

      // Opcode decode
      stDecode: begin
        nextFetchOffset = 1'b1;
        // Bit 0 picks B for loads, stores and ALU writes
        nextUseB        = romData[0];
        case (opcode)
          loadA, loadB, storeA, storeB: begin
            nextMemWrite = romData[1];
            nextState    = stMemWait;
          end
          aluToA, aluToB: nextState = stAluSave;
          branchEqual: begin
            nextJumpTaken = flags.equal;
            nextState     = stJumpWait;
          end
          branchLess: begin
            nextJumpTaken = flags.less;
            nextState     = stJumpWait;
          end
          branchGreater: begin
            nextJumpTaken = flags.greater;
            nextState     = stJumpWait;
          end
          gotoAddr: begin
            nextJumpTaken = 1'b1;
            nextState     = stJumpWait;
          end
          gotoIdle: nextState = stIdleWait;
          default: begin
            // One-byte no-operation
            nextFetchOffset = 1'b0;
            nextPc          = pc + 1'b1;
            nextState       = stSettle;
          end
        endcase
      end

      // ALU, opcode is still on romData here
      stAluSave: begin
        if (useB) nextRegB = aluResult;
        else nextRegA = aluResult;
        nextPc    = pc + 1'b1;
        nextState = stSettle;
      end

      // Load and store
      stMemWait:  nextState = stMemIssue;
      stMemIssue: begin
        nextPc    = pc + addrWidth'(2);
        nextState = stMemBus;
      end
      stMemBus: begin
        if (done) begin
          if (!memWrite) begin
            if (useB) nextRegB = readData;
            else nextRegA = readData;
          end
          nextState = stDecode;
        end
      end

      // Branch and goto share the target fetch
      stJumpWait: nextState = stJumpLoad;
      stJumpLoad: begin
        nextPc    = jumpTaken ? romData : pc + addrWidth'(2);
        nextState = stSettle;
      end

      stIdleWait: nextState = stIdle;

      default: nextState = stSettle;
    endcase
  end

endmodule

`default_nettype wire
